/* hdl/icacheGeomPkg.sv */
// Fixed cache geometry of four 32-bit words per line and two ways; the set count is a module parameter
package icacheGeomPkg;

  // Fetch address and instruction widths
  localparam int addrWidth = 32;
  localparam int wordBits = 32;

  // Line layout, four words per line
  localparam int lineWords = 4;
  localparam int offsetBits = 2;

  // Byte address bits below the word, always zero on the bus
  localparam int byteBits = 2;

  // Way identifier, also used as the LRU encoding.
  // An LRU bit names the way to be replaced next, so a cleared
  // LRU bit points at way2 and a set one at way1
  typedef enum logic {
    way2 = 1'b0,
    way1 = 1'b1
  } wayT;

endpackage

/* hdl/icacheBusPkg.sv */
// Bundles for the refill bus and the core fetch answer; bus addresses are always word aligned
package icacheBusPkg;

  // Request to the refill bus, one word per accepted cycle
  typedef struct packed {
    logic valid;
    logic [icacheGeomPkg::addrWidth-1:0] addr;
  } busReqT;

  // Response from the refill bus, data is taken when ready is high
  typedef struct packed {
    logic ready;
    logic [icacheGeomPkg::wordBits-1:0] data;
  } busRspT;

  // Answer to the core, instr is meaningful only with stall low
  typedef struct packed {
    logic stall;
    logic [icacheGeomPkg::wordBits-1:0] instr;
  } fetchRspT;

endpackage

/* hdl/icacheController.sv */
// Core must hold address and valid while stalled; enable may only change between fetches
`timescale 1ns/10ps

module icacheController #(
  parameter int setBits = 4,
  localparam int tagBits = icacheGeomPkg::addrWidth - setBits
                         - icacheGeomPkg::offsetBits - icacheGeomPkg::byteBits
) (
  input  logic clk,
  input  logic reset,
  input  logic enable,
  input  logic fetchValid,
  input  logic [icacheGeomPkg::offsetBits-1:0] wordOffset,
  input  logic [tagBits-1:0] tag,
  input  logic [tagBits-1:0] w1Tag,
  input  logic [tagBits-1:0] w2Tag,
  input  logic w1Valid,
  input  logic w2Valid,
  input  icacheGeomPkg::wayT lru,
  input  icacheBusPkg::busRspT busRsp,
  output icacheGeomPkg::wayT hitWay,
  output logic stall,
  output logic busValid,
  output logic [icacheGeomPkg::offsetBits-1:0] fillWord,
  output logic w1We,
  output logic w2We,
  output logic tagWe,
  output logic lruWe,
  output icacheGeomPkg::wayT lruNext,
  output logic bypassValid
);

  typedef enum logic [1:0] {
    READY,
    MEMREAD,
    NEXTINSTR
  } stateT;

  stateT state;
  stateT nextState;

  logic w1Hit;
  logic w2Hit;
  logic hit;
  logic accept;
  logic lastWord;
  logic bypassMode;
  logic curBypass;
  logic [icacheGeomPkg::offsetBits-1:0] counter;
  icacheGeomPkg::wayT victim;

  // Tag compare, a disabled cache never hits
  assign w1Hit = w1Valid & (tag == w1Tag);
  assign w2Hit = w2Valid & (tag == w2Tag);
  assign hit = enable & fetchValid & (w1Hit | w2Hit);

  // An invalid way is filled first, otherwise the LRU way
  always_comb begin
    if (w1Valid ^ w2Valid) begin
      victim = w1Valid ? icacheGeomPkg::way2 : icacheGeomPkg::way1;
    end else begin
      victim = lru;
    end
  end

  // Hit way while answering, victim way while refilling
  assign hitWay = hit ? (w1Hit ? icacheGeomPkg::way1 : icacheGeomPkg::way2) : victim;
  assign lruNext = (hitWay == icacheGeomPkg::way1) ? icacheGeomPkg::way2 : icacheGeomPkg::way1;

  // Mode is sampled from enable at the start of an access
  assign curBypass = (state == READY) ? ~enable : bypassMode;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      bypassMode <= 1'b0;
    end else if (state == READY) begin
      bypassMode <= ~enable;
    end
  end

  assign busValid = ((state == READY) & fetchValid & ~hit) | (state == MEMREAD);
  assign accept = busValid & busRsp.ready;
  assign lastWord = counter == icacheGeomPkg::offsetBits'(icacheGeomPkg::lineWords - 1);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= READY;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      READY: begin
        if (fetchValid & ~hit) begin
          // A bypass word taken right away skips MEMREAD
          nextState = (curBypass & busRsp.ready) ? NEXTINSTR : MEMREAD;
        end
      end
      MEMREAD: begin
        if (busRsp.ready & (bypassMode | lastWord)) begin
          nextState = NEXTINSTR;
        end
      end
      NEXTINSTR: nextState = READY;
      default: nextState = READY;
    endcase
  end

  // Burst counter, moves only on accepted words
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      counter <= '0;
    end else if (state == NEXTINSTR) begin
      counter <= '0;
    end else if (accept) begin
      counter <= counter + 1'b1;
    end
  end

  // Bypass fetches read the word the core asked for
  assign fillWord = curBypass ? wordOffset : counter;

  assign w1We = accept & ~curBypass & (victim == icacheGeomPkg::way1);
  assign w2We = accept & ~curBypass & (victim == icacheGeomPkg::way2);

  // Tag, valid and LRU land together once the line is complete
  assign tagWe = (state == NEXTINSTR) & ~bypassMode;
  assign lruWe = hit | tagWe;

  assign bypassValid = (state == NEXTINSTR) & bypassMode;

  // Refill keeps the core waiting through NEXTINSTR, bypass answers there
  always_comb begin
    case (state)
      READY: stall = fetchValid & ~hit;
      MEMREAD: stall = 1'b1;
      NEXTINSTR: stall = ~bypassMode;
      default: stall = 1'b1;
    endcase
  end

endmodule

/* hdl/icacheTagArray.sv */
// Tags have no reset and are only meaningful behind a set valid bit; reads are combinational
`timescale 1ns/10ps

module icacheTagArray #(
  parameter int setBits = 4,
  localparam int tagBits = icacheGeomPkg::addrWidth - setBits
                         - icacheGeomPkg::offsetBits - icacheGeomPkg::byteBits
) (
  input  logic clk,
  input  logic reset,
  input  logic [setBits-1:0] setIndex,
  input  logic tagWe,
  input  logic lruWe,
  input  icacheGeomPkg::wayT fillWay,
  input  logic [tagBits-1:0] fillTag,
  input  icacheGeomPkg::wayT lruNext,
  output logic [tagBits-1:0] w1Tag,
  output logic [tagBits-1:0] w2Tag,
  output logic w1Valid,
  output logic w2Valid,
  output icacheGeomPkg::wayT lru
);

  localparam int numSets = 2 ** setBits;

  logic [tagBits-1:0] w1Tags [numSets];
  logic [tagBits-1:0] w2Tags [numSets];
  logic [numSets-1:0] w1Valids;
  logic [numSets-1:0] w2Valids;
  logic [numSets-1:0] lruBits;

  logic fillW1;

  assign fillW1 = fillWay == icacheGeomPkg::way1;

  // Tag storage
  always_ff @(posedge clk) begin
    if (tagWe) begin
      if (fillW1) begin
        w1Tags[setIndex] <= fillTag;
      end else begin
        w2Tags[setIndex] <= fillTag;
      end
    end
  end

  // Valid bits come up with the tag of the filled way
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      w1Valids <= '0;
      w2Valids <= '0;
    end else if (tagWe) begin
      if (fillW1) begin
        w1Valids[setIndex] <= 1'b1;
      end else begin
        w2Valids[setIndex] <= 1'b1;
      end
    end
  end

  // One LRU bit per set, cleared to way2
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lruBits <= '0;
    end else if (lruWe) begin
      lruBits[setIndex] <= lruNext;
    end
  end

  assign w1Tag = w1Tags[setIndex];
  assign w2Tag = w2Tags[setIndex];
  assign w1Valid = w1Valids[setIndex];
  assign w2Valid = w2Valids[setIndex];
  assign lru = icacheGeomPkg::wayT'(lruBits[setIndex]);

endmodule

/* hdl/icacheDataArray.sv */
// Line storage has no reset; a word is only read after its line was filled and tagged valid
`timescale 1ns/10ps

module icacheDataArray #(
  parameter int setBits = 4
) (
  input  logic clk,
  input  logic [setBits-1:0] setIndex,
  input  logic [icacheGeomPkg::offsetBits-1:0] readWord,
  input  logic [icacheGeomPkg::offsetBits-1:0] fillWord,
  input  logic w1We,
  input  logic w2We,
  input  logic [icacheGeomPkg::wordBits-1:0] fillData,
  input  icacheGeomPkg::wayT readWay,
  output logic [icacheGeomPkg::wordBits-1:0] instr
);

  localparam int depth = (2 ** setBits) * icacheGeomPkg::lineWords;

  logic [icacheGeomPkg::wordBits-1:0] w1Mem [depth];
  logic [icacheGeomPkg::wordBits-1:0] w2Mem [depth];

  logic [setBits+icacheGeomPkg::offsetBits-1:0] wrIndex;
  logic [setBits+icacheGeomPkg::offsetBits-1:0] rdIndex;

  // Words of a line sit next to each other
  assign wrIndex = {setIndex, fillWord};
  assign rdIndex = {setIndex, readWord};

  // One refill word per accepted bus cycle
  always_ff @(posedge clk) begin
    if (w1We) begin
      w1Mem[wrIndex] <= fillData;
    end
    if (w2We) begin
      w2Mem[wrIndex] <= fillData;
    end
  end

  assign instr = (readWay == icacheGeomPkg::way1) ? w1Mem[rdIndex] : w2Mem[rdIndex];

endmodule

/* hdl/icacheTop.sv */
// Read-only cache; no writes, flush or bus errors, and the bus must accept word-aligned bursts
`timescale 1ns/10ps

module icacheTop #(
  parameter int setBits = 4
) (
  input  logic clk,
  input  logic reset,
  input  logic enable,
  input  logic fetchValid,
  input  logic [icacheGeomPkg::addrWidth-1:0] fetchAddr,
  input  icacheBusPkg::busRspT busRsp,
  output icacheBusPkg::fetchRspT fetchRsp,
  output icacheBusPkg::busReqT busReq
);

  localparam int lowBits = icacheGeomPkg::offsetBits + icacheGeomPkg::byteBits;
  localparam int tagBits = icacheGeomPkg::addrWidth - setBits - lowBits;

  logic [tagBits-1:0] tag;
  logic [setBits-1:0] setIndex;
  logic [icacheGeomPkg::offsetBits-1:0] wordOffset;

  logic [tagBits-1:0] w1Tag;
  logic [tagBits-1:0] w2Tag;
  logic w1Valid;
  logic w2Valid;
  icacheGeomPkg::wayT lru;
  icacheGeomPkg::wayT hitWay;
  icacheGeomPkg::wayT lruNext;

  logic stall;
  logic busValid;
  logic [icacheGeomPkg::offsetBits-1:0] fillWord;
  logic w1We;
  logic w2We;
  logic tagWe;
  logic lruWe;
  logic bypassValid;

  logic [icacheGeomPkg::wordBits-1:0] arrayInstr;
  logic [icacheGeomPkg::wordBits-1:0] bypassData;

  // Address split
  assign tag = fetchAddr[icacheGeomPkg::addrWidth-1 -: tagBits];
  assign setIndex = fetchAddr[lowBits +: setBits];
  assign wordOffset = fetchAddr[icacheGeomPkg::byteBits +: icacheGeomPkg::offsetBits];

  icacheController #(.setBits(setBits)) controller (
    .clk, .reset, .enable, .fetchValid, .wordOffset, .tag,
    .w1Tag, .w2Tag, .w1Valid, .w2Valid, .lru, .busRsp,
    .hitWay, .stall, .busValid, .fillWord,
    .w1We, .w2We, .tagWe, .lruWe, .lruNext, .bypassValid
  );

  icacheTagArray #(.setBits(setBits)) tagArray (
    .clk, .reset, .setIndex, .tagWe, .lruWe,
    .fillWay(hitWay), .fillTag(tag), .lruNext,
    .w1Tag, .w2Tag, .w1Valid, .w2Valid, .lru
  );

  icacheDataArray #(.setBits(setBits)) dataArray (
    .clk, .setIndex, .readWord(wordOffset), .fillWord,
    .w1We, .w2We, .fillData(busRsp.data), .readWay(hitWay),
    .instr(arrayInstr)
  );

  // Line base plus burst word, or the fetched word itself when bypassing
  assign busReq.valid = busValid;
  assign busReq.addr = {fetchAddr[icacheGeomPkg::addrWidth-1:lowBits], fillWord,
                        icacheGeomPkg::byteBits'(0)};

  // Last accepted bus word, the answer of a bypass fetch
  always_ff @(posedge clk) begin
    if (busValid & busRsp.ready) begin
      bypassData <= busRsp.data;
    end
  end

  assign fetchRsp.stall = stall;
  assign fetchRsp.instr = bypassValid ? bypassData : arrayInstr;

endmodule

/* tb/icacheTb.sv */
// Assumes the default setBits of 4 and word-aligned fetches; stimulus comes from a fixed LFSR seed
`timescale 1ns/10ps

module icacheTb;

  localparam int setBits = 4;
  localparam int lowBits = icacheGeomPkg::offsetBits + icacheGeomPkg::byteBits;
  localparam int tagBits = icacheGeomPkg::addrWidth - setBits - lowBits;
  localparam int numSets = 2 ** setBits;
  localparam int halfPeriod = 20;
  localparam int randomFetches = 400;
  localparam int totalFetches = randomFetches + 16;
  // Cycles allowed for one fetch, far above a refill with random back-pressure
  localparam int refillBound = 64;
  localparam logic [31:0] memKey = 32'h5eedc0de;

  logic clk;
  logic reset;
  logic enable;
  logic fetchValid;
  logic [31:0] fetchAddr;
  logic busReady;
  icacheBusPkg::busRspT busRsp;
  icacheBusPkg::fetchRspT fetchRsp;
  icacheBusPkg::busReqT busReq;

  logic [31:0] lfsrState;
  int errors;
  int fetches;

  // Reference cache state, an LRU bit of 1 names way1 as next victim
  logic [tagBits-1:0] mTag1 [numSets];
  logic [tagBits-1:0] mTag2 [numSets];
  logic mValid1 [numSets];
  logic mValid2 [numSets];
  logic mLru [numSets];

  icacheTop #(.setBits(setBits)) dut (
    .clk, .reset, .enable, .fetchValid, .fetchAddr, .busRsp, .fetchRsp, .busReq
  );

  always #halfPeriod clk = ~clk;

  // Bus memory, every word holds its own word address scrambled by a key
  function automatic logic [31:0] memWord(input logic [31:0] addr);
    return {2'b00, addr[31:2]} ^ memKey;
  endfunction

  assign busRsp = {busReady, memWord(busReq.addr)};

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic takeBits(input int n, output logic [31:0] value);
    int i;
    value = '0;
    for (i = 0; i < n; i++) begin
      lfsrState = lfsrStep(lfsrState);
      value = {value[30:0], lfsrState[0]};
    end
  endtask

  function automatic logic [31:0] makeAddr(input logic [tagBits-1:0] t, input int s, input int w);
    return {t, setBits'(s), 2'(w), 2'b00};
  endfunction

  function automatic logic [tagBits-1:0] poolTag(input int k);
    return tagBits'(32'h00a3c0 + k * 32'h111);
  endfunction

  function automatic logic predictHit(input logic [31:0] addr);
    int s;
    logic [tagBits-1:0] t;
    s = int'(addr[lowBits +: setBits]);
    t = addr[31 -: tagBits];
    return (mValid1[s] && mTag1[s] == t) || (mValid2[s] && mTag2[s] == t);
  endfunction

  // Hit moves LRU to the other way, a miss fills an invalid way first, else the LRU way
  task automatic updateModel(input logic [31:0] addr);
    int s;
    logic [tagBits-1:0] t;
    logic fillW1;
    s = int'(addr[lowBits +: setBits]);
    t = addr[31 -: tagBits];
    if (mValid1[s] && mTag1[s] == t) begin
      mLru[s] = 1'b0;
    end else if (mValid2[s] && mTag2[s] == t) begin
      mLru[s] = 1'b1;
    end else begin
      if (mValid1[s] != mValid2[s]) begin
        fillW1 = !mValid1[s];
      end else begin
        fillW1 = mLru[s];
      end
      if (fillW1) begin
        mTag1[s] = t;
        mValid1[s] = 1'b1;
        mLru[s] = 1'b0;
      end else begin
        mTag2[s] = t;
        mValid2[s] = 1'b1;
        mLru[s] = 1'b1;
      end
    end
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    errors++;
    $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
  endtask

  task automatic driveReady();
    logic [31:0] bits;
    takeBits(2, bits);
    busReady = bits[1:0] != 2'b00;
  endtask

  // Holds one fetch until stall drops, checking stall, bus addresses and the answer
  task automatic doFetch(input logic [31:0] addr, input logic en, output logic missed);
    logic expHit;
    logic first;
    logic done;
    logic [31:0] lineBase;
    logic [31:0] expAddr;
    int expXfers;
    int xfers;
    expHit = en && predictHit(addr);
    lineBase = {addr[31:lowBits], lowBits'(0)};
    expXfers = expHit ? 0 : (en ? icacheGeomPkg::lineWords : 1);
    xfers = 0;
    first = 1'b1;
    done = 1'b0;
    missed = 1'b0;
    @(negedge clk);
    enable = en;
    fetchAddr = addr;
    fetchValid = 1'b1;
    driveReady();
    while (!done) begin
      // Sample just before the rising edge
      #(halfPeriod - 1);
      expAddr = en ? lineBase + 32'(4 * xfers) : addr;
      if (first) begin
        missed = fetchRsp.stall;
        assert (fetchRsp.stall == !expHit)
          else reportMismatch("fetchRsp.stall", 32'(fetchRsp.stall), 32'(!expHit));
      end
      if (busReq.valid) begin
        assert (xfers < expXfers) else begin
          errors++;
          $display("error at %0t ns: bus request after %0d transfers for fetch %h",
                   $time, xfers, addr);
        end
        assert (busReq.addr == expAddr) else reportMismatch("busReq.addr", busReq.addr, expAddr);
        if (busReady) begin
          xfers++;
        end
      end
      if (!fetchRsp.stall) begin
        assert (fetchRsp.instr == memWord(addr))
          else reportMismatch("fetchRsp.instr", fetchRsp.instr, memWord(addr));
        assert (xfers == expXfers) else begin
          errors++;
          $display("error at %0t ns: fetch %h made %0d bus transfers instead of %0d",
                   $time, addr, xfers, expXfers);
        end
        done = 1'b1;
      end else begin
        @(negedge clk);
        driveReady();
      end
      first = 1'b0;
    end
    if (en) begin
      updateModel(addr);
    end
    fetches++;
  endtask

  task automatic idleCycle();
    @(negedge clk);
    fetchValid = 1'b0;
    #(halfPeriod - 1);
    assert (!busReq.valid) else reportMismatch("busReq.valid", 32'(busReq.valid), 32'd0);
    assert (!fetchRsp.stall) else reportMismatch("fetchRsp.stall", 32'(fetchRsp.stall), 32'd0);
  endtask

  initial begin
    logic missed;
    logic [31:0] bits;
    logic [31:0] addr;
    int conflictMisses;
    int k;
    clk = 1'b0;
    reset = 1'b1;
    enable = 1'b1;
    fetchValid = 1'b0;
    fetchAddr = '0;
    busReady = 1'b0;
    lfsrState = 32'h4313aecb;
    errors = 0;
    fetches = 0;
    for (k = 0; k < numSets; k++) begin
      mTag1[k] = '0;
      mTag2[k] = '0;
      mValid1[k] = 1'b0;
      mValid2[k] = 1'b0;
      mLru[k] = 1'b0;
    end
    repeat (5) @(negedge clk);
    reset = 1'b0;
    idleCycle();

    // Empty cache after reset
    doFetch(makeAddr(poolTag(0), 0, 1), 1'b1, missed);
    assert (missed) else begin
      errors++;
      $display("error: the first fetch after reset did not miss");
    end

    // Three tags through one set, each one evicts the next tag needed
    conflictMisses = 0;
    for (k = 0; k < 9; k++) begin
      doFetch(makeAddr(poolTag(8 + k % 3), 5, k % 4), 1'b1, missed);
      if (missed) begin
        conflictMisses++;
      end
    end
    assert (conflictMisses == 9) else reportMismatch("conflict misses", conflictMisses, 32'd9);

    // Disabled fetches allocate nothing
    addr = makeAddr(poolTag(12), 6, 2);
    doFetch(addr, 1'b0, missed);
    doFetch(addr + 32'd4, 1'b0, missed);
    doFetch(addr, 1'b1, missed);
    assert (missed) else begin
      errors++;
      $display("error: enabled fetch after bypass hit a line that was never filled");
    end
    doFetch(addr + 32'd4, 1'b1, missed);

    // Small tag pool over four sets so lines conflict often
    for (k = 0; k < randomFetches; k++) begin
      takeBits(12, bits);
      addr = makeAddr(poolTag(int'(bits[1:0])), int'(bits[3:2]), int'(bits[5:4]));
      doFetch(addr, bits[8:6] != 3'b000, missed);
      if (bits[11:9] == 3'b000) begin
        idleCycle();
      end
    end

    idleCycle();
    $display("%0d errors in %0d fetches", errors, fetches);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Every fetch and its idle cycle within the bound, plus reset
  initial begin
    #((totalFetches * (refillBound + 1) + 10) * 2 * halfPeriod);
    $display("watchdog: the run did not finish in the expected time");
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* verilog.f */
hdl/icacheGeomPkg.sv
hdl/icacheBusPkg.sv
hdl/icacheController.sv
hdl/icacheTagArray.sv
hdl/icacheDataArray.sv
hdl/icacheTop.sv
tb/icacheTb.sv

/* run.sh */
#!/bin/sh
# Build and run with Verilator; the result is taken from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module icacheTb -Mdir obj_dir \
  && ./obj_dir/VicacheTb > sim.log 2>&1 \
  || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "TEST OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
